//--- debugSub.f
+incdir+hw
hw/debugPkg.sv
hw/stopSync.sv
hw/debugRequestGen.sv
hw/debugPort.sv
hw/debugTarget.sv
hw/debugSubsystem.sv
verif/debugChecker.sv
verif/tbDebugSubsystem.sv

//--- run.sh
#!/bin/sh
# build the debug subsystem testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tbDebugSubsystem \
	-f debugSub.f --Mdir obj_dir -o simDebugSub
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/simDebugSub > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	exit 1
fi
exit 0

//--- verif/debugVectors.txt
// kind addr data exp. 0 write (exp 01 then waits for idle), 1 read expecting exp,
// 2 poll status until (status & data) == exp, 3 test end, 4 snap, 5 same, 6 differs, f end
1 6 00 00	// reset: status clear
1 0 00 00
1 5 00 00
3 0 00 00
0 2 10 00	// address 0x0010
0 3 00 00
0 5 12 01	// MDH with op still nop
0 4 34 00
0 0 03 01	// opMemWrite 0x1234
0 4 78 00
0 5 56 01	// MDH repeats opMemWrite with 0x5678
0 2 10 00	// back to 0x0010
0 3 00 00
0 0 04 01	// opMemRead
0 0 01 01	// opRegRead of srcMemData
1 0 00 34
1 5 00 12
0 0 04 01
0 0 01 01
1 0 00 78
1 5 00 56
3 0 00 00
0 4 a5 00
0 5 c3 01
0 0 12 01	// opRegWrite into r2
0 1 01 00	// srcRegA
0 0 11 01	// opRegRead of r2
1 0 00 a5
1 5 00 c3
3 0 00 00
0 1 02 00	// srcCc
0 4 00 00
0 0 1a 01	// opRegWrite r3 with 0xc300
0 5 00 01	// r3 = 0, zero flag
0 0 01 01
1 0 00 01
0 5 80 01	// MD = 0x8000 with op regRead
0 0 1a 01	// r3 = 0x8000, negative flag
0 0 01 01
1 0 00 02
3 0 00 00
0 7 01 00	// stop
2 0 02 02	// until halted
0 1 03 00	// srcPc
0 0 01 01
4 0 00 00
0 0 01 01
5 0 00 00
0 7 00 00	// run again
2 0 02 00
0 0 01 01
6 0 00 00
3 0 00 00
0 1 00 00	// srcMemData
0 2 0e 00	// address 0x000e
0 3 00 00
0 4 11 00
0 5 22 01
0 0 03 00	// opMemWrite 0x2211, no wait
0 5 99 01	// lands while busy and is dropped
0 0 04 01	// reads 0x0010, still 0x1234
0 0 01 01
1 0 00 34
1 5 00 12
3 0 00 00
f 0 00 00

//--- verif/tbDebugSubsystem.sv
`timescale 1ns/10ps
`default_nettype none

module tbDebugSubsystem;

	logic       clk;
	logic       rstN;
	logic [2:0] hostAddr;
	logic [7:0] hostDin;
	logic       hostWr;
	logic       hostRd;
	wire  [7:0] hostDout;
	logic [3:0] chkKind;
	logic [7:0] expByte;
	logic       testEnd;
	logic       runDone;
	int         errCount;
	logic [7:0] vec [512];	// four entries per vector line
	int         nLines;
	logic       vecLoaded;
	logic       badVec;

	debugSubsystem i_dut (
		.clk     (clk),
		.rstN    (rstN),
		.hostAddr(hostAddr),
		.hostDin (hostDin),
		.hostWr  (hostWr),
		.hostRd  (hostRd),
		.hostDout(hostDout)
	);

	debugChecker hostChecker (
		.clk     (clk),
		.hostRd  (hostRd),
		.hostDout(hostDout),
		.chkKind (chkKind),
		.expByte (expByte),
		.testEnd (testEnd),
		.runDone (runDone),
		.errCount(errCount)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// one host cycle with inputs moving 1 ns after the edge
	task automatic drive(input logic wr, input logic rd, input logic [2:0] addr,
			input logic [7:0] din, input logic [3:0] kind, input logic [7:0] expv,
			input logic endTest);
		@(posedge clk);
		#1;
		hostWr   = wr;
		hostRd   = rd;
		hostAddr = addr;
		hostDin  = din;
		chkKind  = kind;
		expByte  = expv;
		testEnd  = endTest;
	endtask

	task automatic pollStatus(input logic [7:0] mask, input logic [7:0] want);
		logic [7:0] stat;
		do begin
			drive(1'b0, 1'b1, 3'd6, 8'h00, 4'h0, 8'h00, 1'b0);
			@(negedge clk);
			stat = hostDout;
		end while ((stat & mask) != want);
	endtask

	initial begin
		int         i;
		logic [3:0] kind;
		logic [7:0] expv;
		rstN      = 1'b0;
		hostAddr  = 3'd0;
		hostDin   = 8'h00;
		hostWr    = 1'b0;
		hostRd    = 1'b0;
		chkKind   = 4'h0;
		expByte   = 8'h00;
		testEnd   = 1'b0;
		runDone   = 1'b0;
		vecLoaded = 1'b0;
		badVec    = 1'b0;
		nLines    = 0;
		$readmemh("verif/debugVectors.txt", vec);
		while (nLines < 128 && vec[4 * nLines] != 8'h0f) begin
			nLines++;
		end
		vecLoaded = 1'b1;
		repeat (10) @(posedge clk);
		#1;
		rstN = 1'b1;
		for (i = 0; i < nLines; i++) begin
			kind = vec[4 * i][3:0];
			expv = vec[4 * i + 3];
			case (kind)
				4'h0: begin
					drive(1'b1, 1'b0, vec[4 * i + 1][2:0], vec[4 * i + 2], 4'h0, 8'h00, 1'b0);
					if (expv != 8'h00) pollStatus(8'h01, 8'h00);	// until not busy
				end
				4'h1, 4'h4, 4'h5, 4'h6: begin
					drive(1'b0, 1'b1, vec[4 * i + 1][2:0], 8'h00, kind, expv, 1'b0);
				end
				4'h2: pollStatus(vec[4 * i + 2], expv);
				4'h3: drive(1'b0, 1'b0, 3'd0, 8'h00, 4'h0, 8'h00, 1'b1);
				default: begin
					$display("vector line %0d has unknown kind %h", i, kind);
					badVec = 1'b1;
				end
			endcase
		end
		drive(1'b0, 1'b0, 3'd0, 8'h00, 4'h0, 8'h00, 1'b0);
		@(negedge clk);
		runDone = 1'b1;
		#1;
		if (nLines == 0) $display("no vector lines were read");
		if (errCount == 0 && !badVec && nLines > 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// watchdog allows 200 cycles per vector line plus reset
	initial begin
		wait (vecLoaded);
		repeat (nLines * 200 + 20) @(posedge clk);
		$display("watchdog expired, vectors did not finish in %0d cycles", nLines * 200 + 20);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/debugChecker.sv
`timescale 1ns/10ps
`default_nettype none

module debugChecker (
	input  wire       clk,
	input  wire       hostRd,
	input  wire [7:0] hostDout,
	input  wire [3:0] chkKind,	// 1 expect, 4 snap, 5 same as snap, 6 differs from snap
	input  wire [7:0] expByte,
	input  wire       testEnd,
	input  wire       runDone,
	output int        errCount
);

	int         errTotal = 0;
	int         testNum = 1;
	int         checkCount = 0;
	int         testErrs = 0;
	logic [7:0] snapByte = 8'h00;

	assign errCount = errTotal;

	task automatic compareByte(input logic [7:0] want);
		checkCount++;
		if (hostDout !== want) begin
			$display("Fail %0t hostDout expected %h actual %h", $time, want, hostDout);
			errTotal++;
			testErrs++;
		end
	endtask

	// DUT registers and host inputs only move around the rising edge
	always @(negedge clk) begin
		if (hostRd) begin
			case (chkKind)
				4'h1: compareByte(expByte);
				4'h4: snapByte = hostDout;
				4'h5: compareByte(snapByte);
				4'h6: begin
					checkCount++;
					if (hostDout == snapByte) begin
						$display("Fail at %0t: hostDout stayed at %h when it should have changed",
							$time, hostDout);
						errTotal++;
						testErrs++;
					end
				end
				default: ;	// status polls
			endcase
		end
		if (testEnd) begin
			if (testErrs == 0) begin
				$display("test %0d ok", testNum);
			end else begin
				$display("test %0d failed with %0d errors", testNum, testErrs);
			end
			testNum++;
			testErrs = 0;
		end
	end

	always @(posedge runDone) begin
		$display("%0d tests, %0d checks, %0d errors", testNum - 1, checkCount, errTotal);
	end

endmodule

`default_nettype wire

//--- hw/debugSubsystem.sv
`timescale 1ns/10ps
`default_nettype none
`include "debugPort_macros.svh"

module debugSubsystem (
	input  wire                    clk,
	input  wire                    rstN,
	input  wire  [2:0]             hostAddr,
	input  wire  [`DBG_HOST_W-1:0] hostDin,
	input  wire                    hostWr,
	input  wire                    hostRd,
	output logic [`DBG_HOST_W-1:0] hostDout
);

	import debugPkg::*;

	// request handshake and op
	logic                   dbgReq, dbgAck;
	debugOp                 dbgOp;
	logic [3:0]             regAIdx;
	logic                   addrInc, doutLd;
	logic                   dbgStop, halted;

	// data toward the core and sources back
	logic [`DBG_DATA_W-1:0] memAddr, memDataOut;
	logic [`DBG_DATA_W-1:0] srcMemData, srcRegAData, srcCcData, srcPcData;

	debugPort port (
		.clk(clk), .rstN(rstN),
		.hostAddr(hostAddr), .hostDin(hostDin), .hostWr(hostWr), .hostRd(hostRd),
		.hostDout(hostDout),
		.dbgReq(dbgReq), .dbgAck(dbgAck),
		.dbgStop(dbgStop), .halted(halted),
		.dbgOp(dbgOp), .regAIdx(regAIdx),
		.memAddr(memAddr), .memDataOut(memDataOut),
		.addrInc(addrInc), .doutLd(doutLd),
		.srcMemData(srcMemData), .srcRegAData(srcRegAData),
		.srcCcData(srcCcData), .srcPcData(srcPcData)
	);

	debugTarget core (
		.clk(clk), .rstN(rstN),
		.dbgReq(dbgReq), .dbgAck(dbgAck),
		.dbgOp(dbgOp), .regAIdx(regAIdx),
		.memAddr(memAddr), .memDataOut(memDataOut),
		.addrInc(addrInc), .doutLd(doutLd),
		.dbgStop(dbgStop), .halted(halted),
		.srcMemData(srcMemData), .srcRegAData(srcRegAData),
		.srcCcData(srcCcData), .srcPcData(srcPcData)
	);

endmodule

`default_nettype wire

//--- hw/debugTarget.sv
`timescale 1ns/10ps
`default_nettype none
`include "debugPort_macros.svh"

module debugTarget (
	input  wire                    clk,
	input  wire                    rstN,
	input  wire                    dbgReq,
	output logic                   dbgAck,
	input  wire  debugPkg::debugOp dbgOp,
	input  wire  [3:0]             regAIdx,
	input  wire  [`DBG_DATA_W-1:0] memAddr,
	input  wire  [`DBG_DATA_W-1:0] memDataOut,
	output logic                   addrInc,
	output logic                   doutLd,
	input  wire                    dbgStop,
	output logic                   halted,
	output logic [`DBG_DATA_W-1:0] srcMemData,
	output logic [`DBG_DATA_W-1:0] srcRegAData,
	output logic [`DBG_DATA_W-1:0] srcCcData,
	output logic [`DBG_DATA_W-1:0] srcPcData
);

	import debugPkg::*;

	localparam int MemAw = $clog2(`DBG_MEM_WORDS);
	localparam int CntW  = $clog2(`DBG_ACK_LAT + 1);
	localparam logic [CntW-1:0] LastCnt = CntW'(`DBG_ACK_LAT - 1);

	logic [CntW-1:0]        ackCnt;
	logic [`DBG_DATA_W-1:0] regFile [16];
	logic [`DBG_DATA_W-1:0] mem [`DBG_MEM_WORDS];
	logic [1:0]             ccFlags;	// bit0 zero, bit1 negative
	logic [`DBG_DATA_W-1:0] pc;
	logic [MemAw-1:0]       wordIdx;

	assign wordIdx = memAddr[MemAw:1];	// byte address to word index

	// acknowledge latency, strobes go out together with dbgAck
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			ackCnt  <= '0;
			dbgAck  <= 1'b0;
			doutLd  <= 1'b0;
			addrInc <= 1'b0;
		end else if (dbgAck) begin
			ackCnt  <= '0;	// req is still high this edge, don't count it again
			dbgAck  <= 1'b0;
			doutLd  <= 1'b0;
			addrInc <= 1'b0;
		end else if (dbgReq) begin
			ackCnt <= ackCnt + 1'b1;
			if (ackCnt == LastCnt) begin
				dbgAck  <= 1'b1;
				doutLd  <= (dbgOp == opRegRead);
				addrInc <= (dbgOp == opMemWrite) || (dbgOp == opMemRead);
			end
		end
	end

	// register file and flags
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 16; i++) begin
				regFile[i] <= '0;
			end
			ccFlags <= '0;
		end else if (dbgAck && (dbgOp == opRegWrite)) begin
			regFile[regAIdx] <= memDataOut;
			ccFlags <= {memDataOut[`DBG_DATA_W-1], (memDataOut == '0)};
		end
	end

	// word memory, ops act in the acknowledge cycle
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `DBG_MEM_WORDS; i++) begin
				mem[i] <= '0;
			end
			srcMemData <= '0;
		end else if (dbgAck) begin
			if (dbgOp == opMemWrite) mem[wordIdx] <= memDataOut;
			if (dbgOp == opMemRead) srcMemData <= mem[wordIdx];
		end
	end

	// free running pc, frozen by a stop
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
		end else if (!dbgStop) begin
			pc <= pc + 1'b1;
		end
	end

	assign halted      = dbgStop;
	assign srcRegAData = regFile[regAIdx];
	assign srcCcData   = {{(`DBG_DATA_W-2){1'b0}}, ccFlags};
	assign srcPcData   = pc;

endmodule

`default_nettype wire

//--- hw/debugPort.sv
`timescale 1ns/10ps
`default_nettype none
`include "debugPort_macros.svh"

module debugPort (
	input  wire                    clk,
	input  wire                    rstN,
	input  wire  [2:0]             hostAddr,
	input  wire  [`DBG_HOST_W-1:0] hostDin,
	input  wire                    hostWr,
	input  wire                    hostRd,
	output logic [`DBG_HOST_W-1:0] hostDout,
	output logic                   dbgReq,
	input  wire                    dbgAck,
	output logic                   dbgStop,
	input  wire                    halted,
	output debugPkg::debugOp       dbgOp,
	output logic [3:0]             regAIdx,
	output logic [`DBG_DATA_W-1:0] memAddr,
	output logic [`DBG_DATA_W-1:0] memDataOut,
	input  wire                    addrInc,
	input  wire                    doutLd,
	input  wire  [`DBG_DATA_W-1:0] srcMemData,
	input  wire  [`DBG_DATA_W-1:0] srcRegAData,
	input  wire  [`DBG_DATA_W-1:0] srcCcData,
	input  wire  [`DBG_DATA_W-1:0] srcPcData
);

	import debugPkg::*;

	logic                   enOpx, enDatax, enMal, enMah, enMdl, enMdh, enStop;
	logic                   trigger;
	logic                   busy;
	logic                   addrLd;
	logic [`DBG_HOST_W-1:0] malBuf, mahBuf;
	logic [`DBG_HOST_W-1:0] mdlReg, mdhReg;
	dataSrc                 dataSel;
	logic [`DBG_DATA_W-1:0] dataMux;
	logic [`DBG_DATA_W-1:0] doutReg;

	// register selects are only live on a host write
	assign enOpx   = hostWr && (hostAddr == `DBG_A_OPX);
	assign enDatax = hostWr && (hostAddr == `DBG_A_DATAX);
	assign enMal   = hostWr && (hostAddr == `DBG_A_MAL);
	assign enMah   = hostWr && (hostAddr == `DBG_A_MAH);
	assign enMdl   = hostWr && (hostAddr == `DBG_A_MDL);
	assign enMdh   = hostWr && (hostAddr == `DBG_A_MDH);
	assign enStop  = hostWr && (hostAddr == `DBG_A_STOP);

	assign trigger = enOpx || enMdh;	// MDH reuses the op already in OPX

	debugRequestGen requestGen (
		.clk    (clk),
		.rstN   (rstN),
		.trigger(trigger),
		.dbgAck (dbgAck),
		.dbgReq (dbgReq),
		.busy   (busy)
	);

	stopSync stopper (
		.clk    (clk),
		.rstN   (rstN),
		.stopWr (enStop),
		.stopBit(hostDin[0]),
		.dbgStop(dbgStop)
	);

	// op, reg index and memory data stay put while a request is in flight,
	// so a dropped trigger leaves no trace in them
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			dbgOp   <= opNop;
			regAIdx <= '0;
			mdlReg  <= '0;
			mdhReg  <= '0;
			dataSel <= debugPkg::srcMemData;
		end else begin
			if (enOpx && !busy) begin
				dbgOp   <= debugOp'(hostDin[2:0]);
				regAIdx <= hostDin[6:3];
			end
			if (enMdl && !busy) mdlReg <= hostDin;
			if (enMdh && !busy) mdhReg <= hostDin;
			if (enDatax) dataSel <= dataSrc'(hostDin[1:0]);
		end
	end

	assign memDataOut = {mdhReg, mdlReg};

	// the counter picks up the address buffers one cycle after MAH
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			malBuf <= '0;
			mahBuf <= '0;
			addrLd <= 1'b0;
		end else begin
			if (enMal) malBuf <= hostDin;
			if (enMah) mahBuf <= hostDin;
			addrLd <= enMah;
		end
	end

	// byte address of a word with bit 0 always zero
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			memAddr <= '0;
		end else if (addrLd) begin
			memAddr <= {mahBuf, malBuf[`DBG_HOST_W-1:1], 1'b0};
		end else if (addrInc) begin
			memAddr <= {memAddr[`DBG_DATA_W-1:1] + 1'b1, 1'b0};
		end
	end

	// data-out source select
	always_comb begin
		case (dataSel)
			debugPkg::srcMemData: dataMux = srcMemData;
			debugPkg::srcRegA:    dataMux = srcRegAData;
			debugPkg::srcCc:      dataMux = srcCcData;
			default:              dataMux = srcPcData;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			doutReg <= '0;
		end else if (doutLd) begin
			doutReg <= dataMux;
		end
	end

	// MDH address returns the high byte of data-out
	always_comb begin
		case (hostAddr)
			`DBG_A_MDH:  hostDout = doutReg[`DBG_DATA_W-1:`DBG_HOST_W];
			`DBG_A_STAT: hostDout = {{(`DBG_HOST_W-2){1'b0}}, halted, busy};
			default:     hostDout = doutReg[`DBG_HOST_W-1:0];
		endcase
	end

	// the core may sample the op on any cycle of the handshake
	opHeldDuringReq: assert property (
		@(posedge clk) disable iff (!rstN)
		dbgReq |=> $stable(dbgOp)
	);

	hostStrobesExcl: assert property (
		@(posedge clk) disable iff (!rstN)
		!(hostRd && hostWr)
	);

endmodule

`default_nettype wire

//--- hw/debugRequestGen.sv
`timescale 1ns/10ps
`default_nettype none

module debugRequestGen (
	input  wire  clk,
	input  wire  rstN,
	input  wire  trigger,
	input  wire  dbgAck,
	output logic dbgReq,
	output logic busy
);

	import debugPkg::*;

	reqState state;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= reqIdle;
		end else begin
			case (state)
				reqIdle: begin
					if (trigger) begin
						state <= reqActive;	// triggers arriving later are dropped
					end
				end
				reqActive: begin
					if (dbgAck) begin
						state <= reqDone;
					end
				end
				// one cycle with the request down before a new trigger is taken
				reqDone: state <= reqIdle;
				default: state <= reqIdle;
			endcase
		end
	end

	assign dbgReq = (state == reqActive);
	assign busy   = (state != reqIdle);	// trigger to request drop, host polls this

	// the target must only answer a request that is still up
	ackInsideReq: assert property (
		@(posedge clk) disable iff (!rstN)
		dbgAck |-> dbgReq
	);

endmodule

`default_nettype wire

//--- hw/stopSync.sv
`timescale 1ns/10ps
`default_nettype none

module stopSync (
	input  wire  clk,
	input  wire  rstN,
	input  wire  stopWr,
	input  wire  stopBit,
	output logic dbgStop
);

	logic stopFlag;
	logic stopMeta;

	// host side flag, written from STOP bit 0
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			stopFlag <= 1'b0;
		end else if (stopWr) begin
			stopFlag <= stopBit;
		end
	end

	// two flops toward the core
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			stopMeta <= 1'b0;
			dbgStop  <= 1'b0;
		end else begin
			stopMeta <= stopFlag;
			dbgStop  <= stopMeta;
		end
	end

endmodule

`default_nettype wire

//--- hw/debugPkg.sv
`default_nettype none

package debugPkg;

	// operation requested from the core, OPX bits 2:0
	typedef enum logic [2:0] {
		opNop      = 3'd0,
		opRegRead  = 3'd1,	// data-out <= selected source
		opRegWrite = 3'd2,	// reg A <= memory-data word
		opMemWrite = 3'd3,	// mem[addr] <= memory-data word, addr++
		opMemRead  = 3'd4	// read-data source <= mem[addr], addr++
	} debugOp;

	// data-out source, DATAX bits 1:0
	typedef enum logic [1:0] {
		srcMemData = 2'd0,
		srcRegA    = 2'd1,
		srcCc      = 2'd2,
		srcPc      = 2'd3
	} dataSrc;

	// request handshake toward the core
	typedef enum logic [1:0] {
		reqIdle   = 2'd0,
		reqActive = 2'd1,
		reqDone   = 2'd2
	} reqState;

endpackage

`default_nettype wire

//--- hw/debugPort_macros.svh
`ifndef DEBUG_PORT_MACROS_SVH
`define DEBUG_PORT_MACROS_SVH

// core word and host byte widths
`define DBG_DATA_W 16
`define DBG_HOST_W 8

`define DBG_MEM_WORDS 256	// target memory depth in words

// cycles from the target first sampling dbgReq to dbgAck
`define DBG_ACK_LAT 2

// host register map
`define DBG_A_OPX   3'd0
`define DBG_A_DATAX 3'd1
`define DBG_A_MAL   3'd2
`define DBG_A_MAH   3'd3
`define DBG_A_MDL   3'd4
`define DBG_A_MDH   3'd5
`define DBG_A_STAT  3'd6
`define DBG_A_STOP  3'd7

`endif
